// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_alu
FILELIST  = alu.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG) || ! grep -q "TEST OK" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: alu.f
verilog/alu_pkg.sv
verilog/alu_core_if.sv
verilog/alu_input_stage.sv
verilog/alu_operand_latches.sv
verilog/alu_core.sv
verilog/alu.sv
sim/alu_properties.sv
sim/tb_alu.sv

// File: sim/alu_properties.sv
// Concurrent checks on bus enable and flag updates, bound into the ALU top by the testbench
module alu_properties (
    input logic              clk,
    input logic              arst_n,
    input alu_pkg::bus_src_t bus_sel,                // Internal bus source
    input logic              db_oe,
    input alu_pkg::core_op_t core_op,
    input logic              core_low,
    input logic              core_high,
    input logic              cf,
    input logic              hf,
    input logic              pf,
    input logic              zf
);
    import alu_pkg::*;

    // --------------------
    // Bus enable
    // --------------------
    oe_follows_sel : assert property (@(posedge clk) disable iff (!arst_n)
        db_oe == (bus_sel != BUS_HIGHZ))
        else $error("db_oe does not follow bus_sel");

    // --------------------
    // Flag updates
    // --------------------
    // CF, PF and ZF only move on the high step, HF only on the low step
    flags_hold : assert property (@(posedge clk) disable iff (!arst_n)
        !core_high |=> $stable({cf, pf, zf}))
        else $error("cf, pf or zf changed without core_high");

    hf_holds : assert property (@(posedge clk) disable iff (!arst_n)
        !core_low |=> $stable(hf))
        else $error("hf changed without core_low");

    logic_clears_cf : assert property (@(posedge clk) disable iff (!arst_n)
        (core_high && core_op != CORE_ADD) |=> !cf)
        else $error("cf set after a logic operation");

endmodule

// File: sim/tb_alu.sv
// Table-driven testbench for the nibble ALU; run through the file list with the ALU top as DUT
module tb_alu;
    import alu_pkg::*;

    typedef enum logic [1:0] {ROW_SHIFT, ROW_BSEL, ROW_OP, ROW_ZERO} row_kind_t;
    typedef struct packed {
        row_kind_t  kind;
        logic [7:0] a;                              // Operand A, shifter input or bsel
        logic [7:0] b;                              // Operand B
        core_op_t   op;
        logic [5:0] ctl;                            // {neg, cin, sh_en, sh_in, sh_right, sh_sra}
    } row_t;

    localparam int clk_period     = 20;
    localparam int reset_cycles   = 16;
    localparam int cycles_per_row = 8;              // Longest row needs 5
    localparam int num_rows       = 33;

    logic clk = 1'b0;
    logic arst_n;
    logic [7:0] db_in;
    bus_src_t bus_sel;
    logic shift_en, shift_in, shift_right, shift_sra;
    logic [2:0] bsel;
    logic op1_load, op2_load, op2_neg, op2_high;
    logic [1:0] op1_src, op2_src;
    core_op_t core_op;
    logic core_cf_in, core_low, core_high;
    logic [7:0] db_out;
    logic db_oe, shift_cf, cf, hf, pf, zf, low_gt_9, high_gt_9, high_eq_9;

    row_t rows [num_rows];
    int   row_count = 0;
    int   seed = 80;                                // Filler operand seed

    alu uut (.*);

    bind alu alu_properties u_props (.*);

    always #(clk_period / 2) clk = ~clk;

    // --------------------
    // Reporting
    // --------------------
    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "Run stopped");
    endtask

    task automatic check_val(input string name, input logic [7:0] act, input logic [7:0] exp);
        assert (act === exp)
        else
            fail_run($sformatf("Mismatch at %0t: %s expected %02h, got %02h",
                               $time, name, exp, act));
    endtask

    task automatic check_bit(input string name, input logic act, input logic exp);
        assert (act === exp)
        else
            fail_run($sformatf("Mismatch at %0t: %s expected %b, got %b", $time, name, exp, act));
    endtask

    // --------------------
    // Reference model
    // --------------------
    function automatic logic [8:0] shift_model(input logic [7:0] a, input logic [3:0] c);
        if (!c[3])
            return {1'b0, a};                       // Pass-through leaves no carry
        if (c[1])
            return {a[0], (c[0] ? a[7] : c[2]), a[7:1]};
        return {a[7], a[6:0], c[2]};
    endfunction

    // Returns {high_eq_9, high_gt_9, low_gt_9, zf, pf, hf, cf, result}
    function automatic logic [14:0] alu_model(input row_t r);
        logic [7:0] b_eff;
        logic [8:0] full;
        logic [4:0] low;
        logic [7:0] res;
        logic       c;
        logic       h;
        b_eff = r.ctl[5] ? ~r.b : r.b;              // Subtract as A + ~B + 1
        full  = {1'b0, r.a} + {1'b0, b_eff} + {8'd0, r.ctl[4]};
        low   = {1'b0, r.a[3:0]} + {1'b0, b_eff[3:0]} + {4'd0, r.ctl[4]};
        case (r.op)
            CORE_AND : res = r.a & b_eff;
            CORE_OR  : res = r.a | b_eff;
            CORE_XOR : res = r.a ^ b_eff;
            default  : res = full[7:0];
        endcase
        c = (r.op == CORE_ADD) ? full[8] : 1'b0;
        h = (r.op == CORE_ADD) ? low[4] : (r.op == CORE_AND);
        return {res[7:4] == 4'd9, res[7:4] > 4'd9, res[3:0] > 4'd9, res == 8'd0, ~^res, h, c, res};
    endfunction

    // --------------------
    // Stimulus
    // --------------------
    function automatic logic [7:0] rand_byte();
        int r;
        r = $random(seed);
        return r[7:0];
    endfunction

    task automatic add_row(input row_kind_t k, input logic [7:0] a, input logic [7:0] b,
                           input core_op_t op, input logic [5:0] ctl);
        rows[row_count] = '{kind: k, a: a, b: b, op: op, ctl: ctl};
        row_count++;
    endtask

    task automatic build_table();
        add_row(ROW_SHIFT, 8'h96, 8'h00, CORE_ADD, 6'b001000);    // SLA
        add_row(ROW_SHIFT, 8'h96, 8'h00, CORE_ADD, 6'b001100);    // Left with fill 1
        add_row(ROW_SHIFT, 8'h4B, 8'h00, CORE_ADD, 6'b001010);    // SRL
        add_row(ROW_SHIFT, 8'h4B, 8'h00, CORE_ADD, 6'b001110);    // Right with fill 1
        add_row(ROW_SHIFT, 8'h82, 8'h00, CORE_ADD, 6'b001011);    // SRA keeps bit 7
        add_row(ROW_SHIFT, 8'h5A, 8'h00, CORE_ADD, 6'b000000);    // No shift
        add_row(ROW_SHIFT, rand_byte(), 8'h00, CORE_ADD, 6'b001100);
        for (int s = 0; s < 8; s++)
            add_row(ROW_BSEL, 8'(s), 8'h00, CORE_ADD, 6'b000000);
        add_row(ROW_OP, 8'h8C, 8'h6D, CORE_ADD, 6'b000000);       // F9 with half carry
        add_row(ROW_OP, 8'hFF, 8'h01, CORE_ADD, 6'b000000);       // Wraps to zero
        add_row(ROW_OP, 8'h0F, 8'h01, CORE_ADD, 6'b000000);
        add_row(ROW_OP, 8'h99, 8'h01, CORE_ADD, 6'b000000);
        add_row(ROW_OP, 8'h80, 8'h80, CORE_ADD, 6'b000000);
        add_row(ROW_OP, rand_byte(), rand_byte(), CORE_ADD, 6'b010000);
        add_row(ROW_OP, 8'h50, 8'h20, CORE_ADD, 6'b110000);       // Subtracts
        add_row(ROW_OP, 8'h20, 8'h50, CORE_ADD, 6'b110000);       // Borrow leaves CF low
        add_row(ROW_OP, 8'h44, 8'h44, CORE_ADD, 6'b110000);
        add_row(ROW_OP, rand_byte(), rand_byte(), CORE_ADD, 6'b110000);
        add_row(ROW_OP, 8'hF0, 8'h3C, CORE_AND, 6'b000000);
        add_row(ROW_OP, 8'h0F, 8'hF0, CORE_AND, 6'b000000);
        add_row(ROW_OP, 8'h12, 8'h84, CORE_OR, 6'b000000);
        add_row(ROW_OP, 8'hAA, 8'hAA, CORE_XOR, 6'b000000);
        add_row(ROW_OP, rand_byte(), rand_byte(), CORE_XOR, 6'b000000);
        add_row(ROW_OP, rand_byte(), rand_byte(), CORE_OR, 6'b000000);
        add_row(ROW_ZERO, rand_byte(), 8'h00, CORE_ADD, 6'b000000);
        add_row(ROW_ZERO, rand_byte(), 8'h00, CORE_ADD, 6'b000000);
    endtask

    task automatic set_idle();
        db_in = 8'h00;
        bus_sel = BUS_HIGHZ;
        {shift_en, shift_in, shift_right, shift_sra} = 4'b0000;
        bsel = 3'd0;
        {op1_load, op2_load, op2_neg, op2_high} = 4'b0000;
        op1_src = 2'd0;
        op2_src = 2'd0;
        core_op = CORE_ADD;
        {core_cf_in, core_low, core_high} = 3'b000;
    endtask

    task automatic drive_after_edge();
        @(posedge clk);
        #2;
        set_idle();                                 // Every cycle starts idle
    endtask

    task automatic run_row(input row_t r);
        logic [8:0]  sh_exp;
        logic [14:0] op_exp;
        case (r.kind)
            ROW_SHIFT :
            begin
                drive_after_edge();
                db_in = r.a;
                {shift_en, shift_in, shift_right, shift_sra} = r.ctl[3:0];
                bus_sel = BUS_SHIFT;
                op1_load = 1'b1;
                sh_exp = shift_model(r.a, r.ctl[3:0]);
                @(negedge clk);
                check_bit("shift_cf", shift_cf, sh_exp[8]);     // Only valid in load cycle
                drive_after_edge();
                bus_sel = BUS_OP1;
                @(negedge clk);
                check_val("db_out", db_out, sh_exp[7:0]);
            end
            ROW_BSEL :
            begin
                drive_after_edge();
                bsel = r.a[2:0];
                bus_sel = BUS_BS;
                op2_load = 1'b1;
                drive_after_edge();
                bus_sel = BUS_OP2;
                @(negedge clk);
                check_bit("db_oe", db_oe, 1'b1);
                check_val("db_out", db_out, 8'b1 << r.a[2:0]);
            end
            ROW_OP :
            begin
                drive_after_edge();
                db_in = r.a;
                bus_sel = BUS_SHIFT;
                op1_load = 1'b1;
                drive_after_edge();
                db_in = r.b;
                bus_sel = BUS_SHIFT;
                op2_load = 1'b1;
                drive_after_edge();
                core_op = r.op;
                {op2_neg, core_cf_in} = r.ctl[5:4];
                core_low = 1'b1;                    // Low nibble step
                drive_after_edge();
                core_op = r.op;
                op2_neg = r.ctl[5];
                op2_high = 1'b1;
                core_high = 1'b1;                   // High nibble step chains from HF
                drive_after_edge();
                bus_sel = BUS_RES;
                op_exp = alu_model(r);
                @(negedge clk);
                check_val("db_out", db_out, op_exp[7:0]);
                check_bit("cf", cf, op_exp[8]);
                check_bit("hf", hf, op_exp[9]);
                check_bit("pf", pf, op_exp[10]);
                check_bit("zf", zf, op_exp[11]);
                check_bit("low_gt_9", low_gt_9, op_exp[12]);
                check_bit("high_gt_9", high_gt_9, op_exp[13]);
                check_bit("high_eq_9", high_eq_9, op_exp[14]);
            end
            default :
            begin
                drive_after_edge();
                db_in = r.a;                        // Non-zero filler first
                bus_sel = BUS_SHIFT;
                {op1_load, op2_load} = 2'b11;
                drive_after_edge();
                {op1_load, op2_load} = 2'b11;
                op1_src = 2'd2;
                op2_src = 2'd2;
                drive_after_edge();
                bus_sel = BUS_OP1;
                @(negedge clk);
                check_val("db_out", db_out, 8'h00);
                drive_after_edge();
                bus_sel = BUS_OP2;
                @(negedge clk);
                check_val("db_out", db_out, 8'h00);
            end
        endcase
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial
    begin
        set_idle();
        arst_n = 1'b0;
        build_table();
        assert (row_count == num_rows)
        else
            fail_run("The stimulus table does not hold the expected number of rows");
        repeat (reset_cycles) @(posedge clk);
        #2 arst_n = 1'b1;
        @(negedge clk);
        check_bit("db_oe", db_oe, 1'b0);            // Idle bus after reset
        check_bit("zf", zf, 1'b0);                  // Flags cleared by reset
        for (int i = 0; i < num_rows; i++)
            run_row(rows[i]);
        $display("TEST OK");
        $finish;
    end

    // Watchdog sized from the table length
    initial
    begin
        #((reset_cycles + num_rows * cycles_per_row) * clk_period);
        fail_run("Timeout: the stimulus table did not finish in time");
    end

endmodule

// File: verilog/alu.sv
// ALU top: internal bus mux, external bus outputs and block instances, driven by a sequencer
module alu (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic [alu_pkg::DATA_W-1:0] db_in,       // External data in
    input  alu_pkg::bus_src_t          bus_sel,     // Internal bus source
    input  logic                       shift_en,
    input  logic                       shift_in,
    input  logic                       shift_right,
    input  logic                       shift_sra,
    input  logic [2:0]                 bsel,
    input  logic                       op1_load,
    input  logic [1:0]                 op1_src,
    input  logic                       op2_load,
    input  logic [1:0]                 op2_src,
    input  logic                       op2_neg,
    input  logic                       op2_high,
    input  alu_pkg::core_op_t          core_op,
    input  logic                       core_cf_in,
    input  logic                       core_low,
    input  logic                       core_high,
    output logic [alu_pkg::DATA_W-1:0] db_out,      // Internal bus to the outside
    output logic                       db_oe,       // Some block drives the bus
    output logic                       shift_cf,    // Shifter carry out
    output logic                       cf,
    output logic                       hf,
    output logic                       pf,
    output logic                       zf,
    output logic                       low_gt_9,
    output logic                       high_gt_9,
    output logic                       high_eq_9
);
    import alu_pkg::*;

    logic [DATA_W-1:0]   bus;                       // Internal bus
    logic [DATA_W-1:0]   shift_out;                 // Shifter result
    logic [DATA_W-1:0]   bs_out;                    // Bit selector result
    logic [DATA_W-1:0]   op1_q;
    logic [DATA_W-1:0]   op2_q;
    logic [DATA_W-1:0]   res_q;
    logic [NIBBLE_W-1:0] low_nib;                   // Low result fed back to the latches

    alu_core_if core_bus ();

    // --------------------
    // Internal bus
    // --------------------
    // One-of-N mux keyed on bus_sel
    always_comb
    begin
        case (bus_sel)
            BUS_OP1   : bus = op1_q;
            BUS_OP2   : bus = op2_q;
            BUS_RES   : bus = res_q;
            BUS_SHIFT : bus = shift_out;
            BUS_BS    : bus = bs_out;
            default   : bus = '0;                   // Idle bus reads zero
        endcase
    end

    assign db_out = bus;
    assign db_oe  = (bus_sel != BUS_HIGHZ);

    // --------------------
    // Blocks
    // --------------------
    alu_input_stage u_input (
        .db_in, .shift_en, .shift_in, .shift_right, .shift_sra, .bsel,
        .shift_out, .shift_cf, .bs_out
    );

    alu_operand_latches u_latches (
        .clk, .arst_n, .bus, .low_nib,
        .op1_load, .op1_src, .op2_load, .op2_src, .op2_neg, .op2_high,
        .op        (core_op),
        .core_low, .core_high,
        .op1_q, .op2_q,
        .cif       (core_bus.src)
    );

    alu_core u_core (
        .clk, .arst_n, .core_cf_in,
        .cif       (core_bus.core),
        .res_q, .low_nib, .cf, .hf, .pf, .zf,
        .low_gt_9, .high_gt_9, .high_eq_9
    );

endmodule

// File: verilog/alu_core.sv
// Nibble-serial add and logic core with result register, flags and decimal-adjust hints
module alu_core (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         core_cf_in,  // Carry into the low step
    alu_core_if.core                     cif,         // Operands and step controls
    output logic [alu_pkg::DATA_W-1:0]   res_q,       // Result register, both nibbles
    output logic [alu_pkg::NIBBLE_W-1:0] low_nib,     // Stored low nibble for feedback
    output logic                         cf,          // Carry out of the high step
    output logic                         hf,          // Half carry from the low step
    output logic                         pf,          // Even parity of the byte
    output logic                         zf,          // Byte is zero
    output logic                         low_gt_9,    // Low nibble above 9
    output logic                         high_gt_9,   // High nibble above 9
    output logic                         high_eq_9    // High nibble equals 9
);
    import alu_pkg::*;

    logic [NIBBLE_W:0]   sum;                       // Nibble sum with carry out
    logic                carry_in;                  // Carry into this step
    logic [NIBBLE_W-1:0] res_nib;                   // Result of this step
    logic                cout;                      // Carry out, zero for logic ops
    logic                hf_d;                      // Half carry rule per opcode
    logic                low_par_q;                 // XOR of the stored low nibble

    // --------------------
    // Nibble datapath
    // --------------------
    always_comb
    begin
        // High step chains from the stored half carry
        carry_in = cif.core_low ? core_cf_in : hf;
        sum      = {1'b0, cif.op1_nib} + {1'b0, cif.op2_nib}
                   + {{NIBBLE_W{1'b0}}, carry_in};
        case (cif.op)
            CORE_ADD : res_nib = sum[NIBBLE_W-1:0];
            CORE_AND : res_nib = cif.op1_nib & cif.op2_nib;
            CORE_OR  : res_nib = cif.op1_nib | cif.op2_nib;
            default  : res_nib = cif.op1_nib ^ cif.op2_nib;
        endcase
        cout = (cif.op == CORE_ADD) ? sum[NIBBLE_W] : 1'b0;
        case (cif.op)
            CORE_ADD : hf_d = sum[NIBBLE_W];        // Real half carry
            CORE_AND : hf_d = 1'b1;                 // Z80 sets H on AND
            default  : hf_d = 1'b0;
        endcase
    end

    // --------------------
    // Result and flags
    // --------------------
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            res_q     <= '0;
            cf        <= 1'b0;
            hf        <= 1'b0;
            pf        <= 1'b0;
            zf        <= 1'b0;
            low_par_q <= 1'b0;
            low_gt_9  <= 1'b0;
            high_gt_9 <= 1'b0;
            high_eq_9 <= 1'b0;
        end
        else
        begin
            if (cif.core_low)
            begin
                res_q[NIBBLE_W-1:0] <= res_nib;
                hf                  <= hf_d;
                low_par_q           <= ^res_nib;    // Odd count in low half
            end
            if (cif.core_high)
            begin
                res_q[DATA_W-1:NIBBLE_W] <= res_nib;
                cf        <= cout;
                pf        <= ~(^res_nib ^ low_par_q);       // Set on even ones
                zf        <= (res_nib == '0) && (res_q[NIBBLE_W-1:0] == '0);
                // DAA hints, the sequencer builds the correction from these
                low_gt_9  <= res_q[NIBBLE_W-1:0] > 4'd9;
                high_gt_9 <= res_nib > 4'd9;
                high_eq_9 <= res_nib == 4'd9;
            end
        end
    end

    assign low_nib = res_q[NIBBLE_W-1:0];

endmodule

// File: verilog/alu_core_if.sv
// Operand nibbles and step controls from the operand latches to the ALU core
interface alu_core_if;
    import alu_pkg::*;

    logic [NIBBLE_W-1:0] op1_nib;           // Selected OP1 half
    logic [NIBBLE_W-1:0] op2_nib;           // Selected, maybe complemented OP2 half
    core_op_t            op;                // Operation for this step
    logic                core_low;          // Low nibble step this edge
    logic                core_high;         // High nibble step this edge

    // Operand latches drive everything
    modport src (
        output op1_nib, op2_nib, op, core_low, core_high
    );

    // Core only consumes
    modport core (
        input op1_nib, op2_nib, op, core_low, core_high
    );

endinterface

// File: verilog/alu_input_stage.sv
// Input shifter and one-hot bit selector feeding the internal bus of the ALU top
module alu_input_stage (
    input  logic [alu_pkg::DATA_W-1:0] db_in,       // External data in
    input  logic                       shift_en,    // Shift one place vs. pass-through
    input  logic                       shift_in,    // Fill bit for the vacated end
    input  logic                       shift_right, // Right (1) or left (0)
    input  logic                       shift_sra,   // Arithmetic right, keep bit 7
    input  logic [2:0]                 bsel,        // Bit to generate
    output logic [alu_pkg::DATA_W-1:0] shift_out,   // Shifter result
    output logic                       shift_cf,    // Bit shifted out
    output logic [alu_pkg::DATA_W-1:0] bs_out       // One-hot at bsel
);
    import alu_pkg::*;

    logic msb_fill;                                 // Top bit on a right shift

    // --------------------
    // Shifter
    // --------------------
    assign msb_fill = shift_sra ? db_in[DATA_W-1] : shift_in; // SRA keeps sign

    always_comb
    begin
        if (!shift_en)
        begin
            shift_out = db_in;                      // Plain load path
            shift_cf  = 1'b0;
        end
        else if (shift_right)
        begin
            shift_out = {msb_fill, db_in[DATA_W-1:1]};
            shift_cf  = db_in[0];                   // Bit 0 falls out
        end
        else
        begin
            shift_out = {db_in[DATA_W-2:0], shift_in};
            shift_cf  = db_in[DATA_W-1];            // Bit 7 falls out
        end
    end

    // --------------------
    // Bit selector
    // --------------------
    // Used by BIT/SET/RES style masks, exactly one bit set
    always_comb
    begin
        bs_out       = '0;
        bs_out[bsel] = 1'b1;
    end

endmodule

// File: verilog/alu_operand_latches.sv
// OP1 and OP2 registers with load-source muxes and the nibble selection toward the core
module alu_operand_latches (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic [alu_pkg::DATA_W-1:0]   bus,        // Internal bus value
    input  logic [alu_pkg::NIBBLE_W-1:0] low_nib,    // Stored low result from the core
    input  logic                         op1_load,   // Sample OP1 this edge
    input  logic [1:0]                   op1_src,    // 0 bus, 1 low nibble, 2 zero
    input  logic                         op2_load,   // Sample OP2 this edge
    input  logic [1:0]                   op2_src,    // 0 bus, 1 low nibble x2, 2 zero
    input  logic                         op2_neg,    // Complement OP2 into the core
    input  logic                         op2_high,   // Use OP2 high half
    input  alu_pkg::core_op_t            op,         // Core operation from the sequencer
    input  logic                         core_low,   // Low nibble step
    input  logic                         core_high,  // High nibble step
    output logic [alu_pkg::DATA_W-1:0]   op1_q,      // OP1 register
    output logic [alu_pkg::DATA_W-1:0]   op2_q,      // OP2 register
    alu_core_if.src                      cif         // Toward the core
);
    import alu_pkg::*;

    logic [DATA_W-1:0]   op1_d;                      // Next OP1 on load
    logic [DATA_W-1:0]   op2_d;                      // Next OP2 on load
    logic [NIBBLE_W-1:0] op2_half;                   // OP2 half before negation

    // --------------------
    // Load sources
    // --------------------
    always_comb
    begin
        case (op1_src)
            2'd0    : op1_d = bus;
            2'd1    : op1_d = {{NIBBLE_W{1'b0}}, low_nib};  // Low result in low half
            default : op1_d = '0;                   // Zero, code 3 treated the same
        endcase
        case (op2_src)
            2'd0    : op2_d = bus;
            2'd1    : op2_d = {low_nib, low_nib};   // Replicated into both halves
            default : op2_d = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            op1_q <= '0;
            op2_q <= '0;
        end
        else
        begin
            if (op1_load)
                op1_q <= op1_d;
            if (op2_load)
                op2_q <= op2_d;
        end
    end

    // --------------------
    // Nibble selection
    // --------------------
    assign op2_half = op2_high ? op2_q[DATA_W-1:NIBBLE_W] : op2_q[NIBBLE_W-1:0];

    assign cif.op1_nib   = core_low ? op1_q[NIBBLE_W-1:0] : op1_q[DATA_W-1:NIBBLE_W];
    assign cif.op2_nib   = op2_neg ? ~op2_half : op2_half;  // Subtract as A + ~B + 1
    assign cif.op        = op;
    assign cif.core_low  = core_low;
    assign cif.core_high = core_high;

endmodule

// File: verilog/alu_pkg.sv
// Shared widths and enums for the nibble ALU; every block imports what it uses from here
package alu_pkg;

    // --------------------
    // Datapath widths
    // --------------------
    localparam int NIBBLE_W = 4;            // One core step works on a nibble
    localparam int DATA_W   = 8;            // External and internal data bus

    // --------------------
    // Internal bus sources
    // --------------------
    // At most one block drives the internal bus in any cycle
    typedef enum logic [2:0] {
        BUS_HIGHZ = 3'd0,                   // Idle bus reads as zero
        BUS_OP1   = 3'd1,                   // OP1 register
        BUS_OP2   = 3'd2,                   // OP2 register
        BUS_RES   = 3'd3,                   // Result register
        BUS_SHIFT = 3'd4,                   // Input shifter of db_in
        BUS_BS    = 3'd5                    // One-hot bit selector
    } bus_src_t;

    // --------------------
    // Core operations
    // --------------------
    // One opcode instead of separate R/S/V controls
    typedef enum logic [1:0] {
        CORE_ADD = 2'd0,                    // Add with carry or subtract via op2_neg
        CORE_AND = 2'd1,                    // Bitwise AND that sets HF
        CORE_OR  = 2'd2,                    // Bitwise OR
        CORE_XOR = 2'd3                     // Bitwise XOR
    } core_op_t;

endpackage
